//--- common/decode_pkg.sv
package decode_pkg;

	// one instruction word seen through each RV32 format
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
		struct packed {
			logic [6:0] imm11_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm4_0;
			logic [6:0] opcode;
		} s;
		struct packed {
			logic       imm12;
			logic [5:0] imm10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm4_1;
			logic       imm11;
			logic [6:0] opcode;
		} b;
		struct packed {
			logic [19:0] imm;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u;
		struct packed {
			logic       imm20;
			logic [9:0] imm10_1;
			logic       imm11;
			logic [7:0] imm19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j;
	} inst_t;

	typedef enum logic [1:0] {
		FU_ALU,
		FU_BTU,
		FU_LSU,
		FU_MULT
	} fu_t;

	typedef enum logic [4:0] {
		ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND,
		ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
		BTU_JAL, BTU_JALR, BTU_BEQ, BTU_BNE,
		BTU_BLT, BTU_BGE, BTU_BLTU, BTU_BGEU,
		MULT_MUL, MULT_MULH, MULT_MULHSU, MULT_MULHU,
		LSU_LB, LSU_LH, LSU_LW, LSU_LBU,
		LSU_LHU, LSU_SB, LSU_SH, LSU_SW
	} func_t;

	typedef enum logic [2:0] {
		IMM_I,
		IMM_S,
		IMM_B,
		IMM_U,
		IMM_J
	} imm_fmt_t;

	typedef struct packed {
		logic [4:0] src1;
		logic [4:0] src2;
		logic [4:0] dest;
	} arch_reg_t;

	typedef struct packed {
		logic        valid;
		fu_t         fu;
		func_t       func;
		arch_reg_t   arch_reg;
		logic [31:0] imm;
		logic        rs1_valid;
		logic        rs2_valid;
		logic        imm_valid;
		logic        pc_valid;
	} decoded_pack_t;

	// a bubble, also the contents of an empty stage register
	localparam decoded_pack_t NOOP_PACK = '{
		valid: 1'b0, fu: FU_ALU, func: ALU_ADD, arch_reg: '0, imm: '0,
		rs1_valid: 1'b0, rs2_valid: 1'b0, imm_valid: 1'b0, pc_valid: 1'b0
	};

	// major opcodes
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	// funct3 for the integer ops, both immediate and register forms
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// loads and stores share the width encoding
	localparam logic [2:0] F3_BYTE  = 3'b000;
	localparam logic [2:0] F3_HALF  = 3'b001;
	localparam logic [2:0] F3_WORD  = 3'b010;
	localparam logic [2:0] F3_BYTEU = 3'b100;
	localparam logic [2:0] F3_HALFU = 3'b101;

	localparam logic [2:0] F3_JALR   = 3'b000;
	localparam logic [2:0] F3_MUL    = 3'b000;
	localparam logic [2:0] F3_MULH   = 3'b001;
	localparam logic [2:0] F3_MULHSU = 3'b010;
	localparam logic [2:0] F3_MULHU  = 3'b011;
	localparam logic [2:0] F3_CSRRW  = 3'b001;
	localparam logic [2:0] F3_CSRRS  = 3'b010;
	localparam logic [2:0] F3_CSRRC  = 3'b011;

	localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
	localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;
	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

	localparam logic [31:0] WFI_INST = 32'h1050_0073;

endpackage

//--- decode/imm_gen.sv
`timescale 1ns/100ps

module imm_gen import decode_pkg::*; (
	input  inst_t       inst,
	input  imm_fmt_t    fmt,
	output logic [31:0] imm
);

	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;

	// bit 31 of the word is the sign in every format
	assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
	assign imm_s = {{20{inst.s.imm11_5[6]}}, inst.s.imm11_5, inst.s.imm4_0};

	// branch and jump offsets are halfword aligned
	assign imm_b = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
		inst.b.imm10_5, inst.b.imm4_1, 1'b0};
	assign imm_j = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
		inst.j.imm11, inst.j.imm10_1, 1'b0};

	assign imm_u = {inst.u.imm, 12'b0};

	always_comb begin
		case (fmt)
			IMM_I:   imm = imm_i;
			IMM_S:   imm = imm_s;
			IMM_B:   imm = imm_b;
			IMM_U:   imm = imm_u;
			IMM_J:   imm = imm_j;
			default: imm = '0;
		endcase
	end

endmodule

//--- decode/decoder.sv
`timescale 1ns/100ps

module decoder import decode_pkg::*; #(
	parameter int PC_WIDTH = 32
) (
	input  logic                in_valid,
	input  inst_t               inst,
	input  logic [PC_WIDTH-1:0] in_pc,
	output logic                csr_op,
	output logic                halt,
	output logic                illegal,
	output logic [PC_WIDTH-1:0] out_pc,
	output decoded_pack_t       decoded_pack
);

	imm_fmt_t    fmt;
	logic [31:0] imm;
	decoded_pack_t pack;

	imm_gen u_imm_gen (
		.inst (inst),
		.fmt  (fmt),
		.imm  (imm)
	);

	// the PC is not part of the packet and travels beside it
	assign out_pc = in_pc;

	// immediate format follows the major opcode alone
	always_comb begin
		case (inst.r.opcode)
			OP_STORE:         fmt = IMM_S;
			OP_BRANCH:        fmt = IMM_B;
			OP_LUI, OP_AUIPC: fmt = IMM_U;
			OP_JAL:           fmt = IMM_J;
			default:          fmt = IMM_I;
		endcase
	end

	always_comb begin
		pack = NOOP_PACK;
		csr_op = 1'b0;
		halt = 1'b0;
		illegal = 1'b0;

		if (in_valid) begin
			case (inst.r.opcode)
				OP_LUI, OP_AUIPC: begin
					pack.arch_reg.dest = inst.u.rd;
					pack.imm_valid = 1'b1;
					pack.pc_valid = (inst.r.opcode == OP_AUIPC);
				end
				OP_JAL: begin
					pack.fu = FU_BTU;
					pack.func = BTU_JAL;
					pack.arch_reg.dest = inst.j.rd;
					pack.imm_valid = 1'b1;
					pack.pc_valid = 1'b1;
				end
				OP_JALR: begin
					pack.fu = FU_BTU;
					pack.func = BTU_JALR;
					pack.arch_reg.src1 = inst.i.rs1;
					pack.arch_reg.dest = inst.i.rd;
					pack.rs1_valid = 1'b1;
					pack.imm_valid = 1'b1;
					pack.pc_valid = 1'b1;
					illegal = (inst.i.funct3 != F3_JALR);
				end
				OP_BRANCH: begin
					pack.fu = FU_BTU;
					pack.arch_reg.src1 = inst.b.rs1;
					pack.arch_reg.src2 = inst.b.rs2;
					pack.rs1_valid = 1'b1;
					pack.rs2_valid = 1'b1;
					pack.imm_valid = 1'b1;
					pack.pc_valid = 1'b1;
					case (inst.b.funct3)
						F3_BEQ:  pack.func = BTU_BEQ;
						F3_BNE:  pack.func = BTU_BNE;
						F3_BLT:  pack.func = BTU_BLT;
						F3_BGE:  pack.func = BTU_BGE;
						F3_BLTU: pack.func = BTU_BLTU;
						F3_BGEU: pack.func = BTU_BGEU;
						default: illegal = 1'b1;
					endcase
				end
				OP_LOAD: begin
					pack.fu = FU_LSU;
					pack.arch_reg.src1 = inst.i.rs1;
					pack.arch_reg.dest = inst.i.rd;
					pack.rs1_valid = 1'b1;
					pack.imm_valid = 1'b1;
					case (inst.i.funct3)
						F3_BYTE:  pack.func = LSU_LB;
						F3_HALF:  pack.func = LSU_LH;
						F3_WORD:  pack.func = LSU_LW;
						F3_BYTEU: pack.func = LSU_LBU;
						F3_HALFU: pack.func = LSU_LHU;
						default:  illegal = 1'b1;
					endcase
				end
				OP_STORE: begin
					// stores write no register
					pack.fu = FU_LSU;
					pack.arch_reg.src1 = inst.s.rs1;
					pack.arch_reg.src2 = inst.s.rs2;
					pack.rs1_valid = 1'b1;
					pack.rs2_valid = 1'b1;
					pack.imm_valid = 1'b1;
					case (inst.s.funct3)
						F3_BYTE: pack.func = LSU_SB;
						F3_HALF: pack.func = LSU_SH;
						F3_WORD: pack.func = LSU_SW;
						default: illegal = 1'b1;
					endcase
				end
				OP_IMM: begin
					pack.arch_reg.src1 = inst.i.rs1;
					pack.arch_reg.dest = inst.i.rd;
					pack.rs1_valid = 1'b1;
					pack.imm_valid = 1'b1;
					case (inst.i.funct3)
						F3_ADD_SUB: pack.func = ALU_ADD;
						F3_SLT:     pack.func = ALU_SLT;
						F3_SLTU:    pack.func = ALU_SLTU;
						F3_XOR:     pack.func = ALU_XOR;
						F3_OR:      pack.func = ALU_OR;
						F3_AND:     pack.func = ALU_AND;
						F3_SLL: begin
							pack.func = ALU_SLL;
							illegal = (inst.r.funct7 != FUNCT7_BASE);
						end
						// upper immediate bits pick logical or arithmetic shift
						default: begin
							if (inst.r.funct7 == FUNCT7_BASE)
								pack.func = ALU_SRL;
							else if (inst.r.funct7 == FUNCT7_ALT)
								pack.func = ALU_SRA;
							else
								illegal = 1'b1;
						end
					endcase
				end
				OP_REG: begin
					pack.arch_reg.src1 = inst.r.rs1;
					pack.arch_reg.src2 = inst.r.rs2;
					pack.arch_reg.dest = inst.r.rd;
					pack.rs1_valid = 1'b1;
					pack.rs2_valid = 1'b1;
					case (inst.r.funct7)
						FUNCT7_BASE: begin
							case (inst.r.funct3)
								F3_ADD_SUB: pack.func = ALU_ADD;
								F3_SLL:     pack.func = ALU_SLL;
								F3_SLT:     pack.func = ALU_SLT;
								F3_SLTU:    pack.func = ALU_SLTU;
								F3_XOR:     pack.func = ALU_XOR;
								F3_SRL_SRA: pack.func = ALU_SRL;
								F3_OR:      pack.func = ALU_OR;
								default:    pack.func = ALU_AND;
							endcase
						end
						FUNCT7_ALT: begin
							if (inst.r.funct3 == F3_ADD_SUB)
								pack.func = ALU_SUB;
							else if (inst.r.funct3 == F3_SRL_SRA)
								pack.func = ALU_SRA;
							else
								illegal = 1'b1;
						end
						FUNCT7_MULDIV: begin
							// only the multiplies, divides are not supported
							pack.fu = FU_MULT;
							case (inst.r.funct3)
								F3_MUL:    pack.func = MULT_MUL;
								F3_MULH:   pack.func = MULT_MULH;
								F3_MULHSU: pack.func = MULT_MULHSU;
								F3_MULHU:  pack.func = MULT_MULHU;
								default:   illegal = 1'b1;
							endcase
						end
						default: illegal = 1'b1;
					endcase
				end
				OP_SYSTEM: begin
					// halt and csr words keep the noop packet
					if (inst == WFI_INST)
						halt = 1'b1;
					else if (inst.i.funct3 == F3_CSRRW || inst.i.funct3 == F3_CSRRS ||
							inst.i.funct3 == F3_CSRRC)
						csr_op = 1'b1;
					else
						illegal = 1'b1;
				end
				default: illegal = 1'b1;
			endcase

			// a rejected word leaves no partial fields behind
			if (illegal)
				pack = NOOP_PACK;
			else
				pack.valid = 1'b1;
		end

		if (pack.imm_valid)
			pack.imm = imm;
	end

	assign decoded_pack = pack;

endmodule

//--- decode/decode_stage.sv
`timescale 1ns/100ps

module decode_stage import decode_pkg::*; #(
	parameter int PC_WIDTH = 32
) (
	input  logic                clock,
	input  logic                rst_n,
	input  logic                flush,
	input  decoded_pack_t       in_pack,
	input  logic [PC_WIDTH-1:0] in_pc,
	input  logic                in_csr_op,
	input  logic                in_halt,
	input  logic                in_illegal,
	output decoded_pack_t       out_pack,
	output logic [PC_WIDTH-1:0] out_pc,
	output logic                out_csr_op,
	output logic                out_illegal,
	output logic                halted
);

	logic accept;

	// once halted nothing new enters, flush wins over any input
	assign accept = ~flush & ~halted;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			out_pack <= NOOP_PACK;
			out_csr_op <= 1'b0;
			out_illegal <= 1'b0;
		end else if (accept) begin
			out_pack <= in_pack;
			out_csr_op <= in_csr_op;
			out_illegal <= in_illegal;
		end else begin
			out_pack <= NOOP_PACK;
			out_csr_op <= 1'b0;
			out_illegal <= 1'b0;
		end
	end

	// sticky until reset
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			halted <= 1'b0;
		else if (accept && in_halt)
			halted <= 1'b1;
	end

	// pc only matters beside a packet, so it just holds otherwise
	always_ff @(posedge clock) begin
		if (accept)
			out_pc <= in_pc;
	end

endmodule

//--- verilog/decode_top.sv
`timescale 1ns/100ps

module decode_top import decode_pkg::*; #(
	parameter int PC_WIDTH = 32
) (
	input  logic                clock,
	input  logic                rst_n,
	input  logic                in_valid,
	input  inst_t               inst,
	input  logic [PC_WIDTH-1:0] in_pc,
	input  logic                flush,
	output decoded_pack_t       decoded_pack,
	output logic [PC_WIDTH-1:0] out_pc,
	output logic                out_csr_op,
	output logic                out_illegal,
	output logic                halted
);

	decoded_pack_t       dec_pack;
	logic [PC_WIDTH-1:0] dec_pc;
	logic                dec_csr_op;
	logic                dec_halt;
	logic                dec_illegal;

	decoder #(
		.PC_WIDTH (PC_WIDTH)
	) u_decoder (
		.in_valid     (in_valid),
		.inst         (inst),
		.in_pc        (in_pc),
		.csr_op       (dec_csr_op),
		.halt         (dec_halt),
		.illegal      (dec_illegal),
		.out_pc       (dec_pc),
		.decoded_pack (dec_pack)
	);

	decode_stage #(
		.PC_WIDTH (PC_WIDTH)
	) u_decode_stage (
		.clock       (clock),
		.rst_n       (rst_n),
		.flush       (flush),
		.in_pack     (dec_pack),
		.in_pc       (dec_pc),
		.in_csr_op   (dec_csr_op),
		.in_halt     (dec_halt),
		.in_illegal  (dec_illegal),
		.out_pack    (decoded_pack),
		.out_pc      (out_pc),
		.out_csr_op  (out_csr_op),
		.out_illegal (out_illegal),
		.halted      (halted)
	);

endmodule

//--- test/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
	parameter int RESET_CYCLES = 5
) (
	input  logic reset_req,
	output logic clock,
	output logic rst_n
);

	int   count = 0;
	logic rst_q = 1'b0;

	assign rst_n = rst_q;

	// 4 ns period
	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// reset held for the first cycles and again whenever the testbench asks
	always @(posedge clock) begin
		if (count < RESET_CYCLES)
			count <= count + 1;
		rst_q <= (count >= RESET_CYCLES - 1) && !reset_req;
	end

endmodule

//--- test/decode_checker.sv
`timescale 1ns/100ps

module decode_checker import decode_pkg::*; #(
	parameter int PC_WIDTH = 32
) (
	input  logic                clock,
	input  logic                rst_n,
	input  logic                in_valid,
	input  logic [31:0]         inst,
	input  logic [PC_WIDTH-1:0] in_pc,
	input  logic                flush,
	input  decoded_pack_t       decoded_pack,
	input  logic [PC_WIDTH-1:0] out_pc,
	input  logic                out_csr_op,
	input  logic                out_illegal,
	input  logic                halted,
	output int                  errors,
	output int                  checks
);

	// operation tables indexed by funct3, unused slots are never selected
	localparam func_t ALU_FUNC [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
	localparam func_t BR_FUNC [8] = '{BTU_BEQ, BTU_BNE, ALU_ADD, ALU_ADD,
		BTU_BLT, BTU_BGE, BTU_BLTU, BTU_BGEU};
	localparam func_t LOAD_FUNC [8] = '{LSU_LB, LSU_LH, LSU_LW, ALU_ADD,
		LSU_LBU, LSU_LHU, ALU_ADD, ALU_ADD};
	localparam func_t STORE_FUNC [8] = '{LSU_SB, LSU_SH, LSU_SW, ALU_ADD,
		ALU_ADD, ALU_ADD, ALU_ADD, ALU_ADD};
	localparam func_t MUL_FUNC [4] = '{MULT_MUL, MULT_MULH, MULT_MULHSU, MULT_MULHU};

	// one bit per funct3 value that is defined
	localparam logic [7:0] BR_OK    = 8'hf3;
	localparam logic [7:0] LOAD_OK  = 8'h37;
	localparam logic [7:0] STORE_OK = 8'h07;

	logic [31:0]         prev_inst = '0;
	logic                prev_valid = 1'b0;
	logic [PC_WIDTH-1:0] prev_pc = '0;
	logic                prev_flush = 1'b0;
	logic                prev_rst_n = 1'b0;
	logic                model_halted = 1'b0;

	initial begin
		errors = 0;
		checks = 0;
	end

	function automatic void decode_ref(
		input  logic [31:0]   w,
		input  logic          v,
		output decoded_pack_t p,
		output logic          csr,
		output logic          halt,
		output logic          ill
	);
		logic [6:0]  op;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic        ok;
		logic        use1;
		logic        use2;
		logic        used;
		logic        usepc;
		logic [31:0] imm;
		fu_t         fu;
		func_t       func;

		op = w[6:0];
		f3 = w[14:12];
		f7 = w[31:25];
		ok = 1'b0;
		use1 = 1'b0;
		use2 = 1'b0;
		used = 1'b0;
		usepc = 1'b0;
		imm = '0;
		fu = FU_ALU;
		func = ALU_ADD;
		p = '0;
		csr = 1'b0;
		halt = 1'b0;
		ill = 1'b0;
		if (!v)
			return;

		case (op)
			OP_LUI, OP_AUIPC: begin
				ok = 1'b1;
				used = 1'b1;
				usepc = (op == OP_AUIPC);
				imm = {w[31:12], 12'h000};
			end
			OP_JAL: begin
				ok = 1'b1;
				fu = FU_BTU;
				func = BTU_JAL;
				used = 1'b1;
				usepc = 1'b1;
				imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			end
			OP_JALR: begin
				ok = (f3 == 3'd0);
				fu = FU_BTU;
				func = BTU_JALR;
				use1 = 1'b1;
				used = 1'b1;
				usepc = 1'b1;
				imm = {{20{w[31]}}, w[31:20]};
			end
			OP_BRANCH: begin
				ok = BR_OK[f3];
				fu = FU_BTU;
				func = BR_FUNC[f3];
				use1 = 1'b1;
				use2 = 1'b1;
				usepc = 1'b1;
				imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			end
			OP_LOAD: begin
				ok = LOAD_OK[f3];
				fu = FU_LSU;
				func = LOAD_FUNC[f3];
				use1 = 1'b1;
				used = 1'b1;
				imm = {{20{w[31]}}, w[31:20]};
			end
			OP_STORE: begin
				ok = STORE_OK[f3];
				fu = FU_LSU;
				func = STORE_FUNC[f3];
				use1 = 1'b1;
				use2 = 1'b1;
				imm = {{20{w[31]}}, w[31:25], w[11:7]};
			end
			OP_IMM: begin
				use1 = 1'b1;
				used = 1'b1;
				imm = {{20{w[31]}}, w[31:20]};
				func = ALU_FUNC[f3];
				if (f3 == 3'd1) begin
					ok = (f7 == FUNCT7_BASE);
				end else if (f3 == 3'd5) begin
					ok = (f7 == FUNCT7_BASE) || (f7 == FUNCT7_ALT);
					if (f7 == FUNCT7_ALT)
						func = ALU_SRA;
				end else begin
					ok = 1'b1;
				end
			end
			OP_REG: begin
				use1 = 1'b1;
				use2 = 1'b1;
				used = 1'b1;
				if (f7 == FUNCT7_BASE) begin
					ok = 1'b1;
					func = ALU_FUNC[f3];
				end else if (f7 == FUNCT7_ALT) begin
					ok = (f3 == 3'd0) || (f3 == 3'd5);
					func = (f3 == 3'd0) ? ALU_SUB : ALU_SRA;
				end else if (f7 == FUNCT7_MULDIV) begin
					ok = (f3 < 3'd4);
					fu = FU_MULT;
					func = MUL_FUNC[f3[1:0]];
				end
			end
			OP_SYSTEM: begin
				halt = (w == WFI_INST);
				csr = !halt && (f3 >= 3'd1) && (f3 <= 3'd3);
				ok = halt || csr;
			end
			default: ok = 1'b0;
		endcase

		ill = !ok;
		if (ok) begin
			p.valid = 1'b1;
			p.fu = fu;
			p.func = func;
			if (use1)
				p.arch_reg.src1 = w[19:15];
			if (use2)
				p.arch_reg.src2 = w[24:20];
			if (used)
				p.arch_reg.dest = w[11:7];
			p.rs1_valid = use1;
			p.rs2_valid = use2;
			p.pc_valid = usepc;
			p.imm_valid = (op != OP_REG) && (op != OP_SYSTEM);
			if (p.imm_valid)
				p.imm = imm;
		end
	endfunction

	task automatic compare_value(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s expected %0h got %0h at %0t", name, exp, act, $time);
		end
	endtask

	// outputs are stable at the falling edge, inputs too
	always @(negedge clock) begin
		decoded_pack_t exp_pack;
		logic          exp_csr;
		logic          exp_halt;
		logic          exp_ill;

		decode_ref(prev_inst, prev_valid, exp_pack, exp_csr, exp_halt, exp_ill);
		if (!rst_n || !prev_rst_n) begin
			model_halted = 1'b0;
			exp_pack = '0;
			exp_csr = 1'b0;
			exp_ill = 1'b0;
		end else if (prev_flush || model_halted) begin
			exp_pack = '0;
			exp_csr = 1'b0;
			exp_ill = 1'b0;
		end else if (exp_halt) begin
			model_halted = 1'b1;
		end

		compare_value("decoded_pack.valid", 64'(exp_pack.valid), 64'(decoded_pack.valid));
		compare_value("decoded_pack.fu", 64'(exp_pack.fu), 64'(decoded_pack.fu));
		compare_value("decoded_pack.func", 64'(exp_pack.func), 64'(decoded_pack.func));
		compare_value("decoded_pack.arch_reg", 64'(exp_pack.arch_reg),
			64'(decoded_pack.arch_reg));
		compare_value("decoded_pack.imm", 64'(exp_pack.imm), 64'(decoded_pack.imm));
		compare_value("decoded_pack.rs1_valid", 64'(exp_pack.rs1_valid),
			64'(decoded_pack.rs1_valid));
		compare_value("decoded_pack.rs2_valid", 64'(exp_pack.rs2_valid),
			64'(decoded_pack.rs2_valid));
		compare_value("decoded_pack.imm_valid", 64'(exp_pack.imm_valid),
			64'(decoded_pack.imm_valid));
		compare_value("decoded_pack.pc_valid", 64'(exp_pack.pc_valid),
			64'(decoded_pack.pc_valid));
		compare_value("out_csr_op", 64'(exp_csr), 64'(out_csr_op));
		compare_value("out_illegal", 64'(exp_ill), 64'(out_illegal));
		compare_value("halted", 64'(model_halted), 64'(halted));
		// pc is only meaningful beside a packet
		if (exp_pack.valid)
			compare_value("out_pc", 64'(prev_pc), 64'(out_pc));

		prev_inst = inst;
		prev_valid = in_valid;
		prev_pc = in_pc;
		prev_flush = flush;
		prev_rst_n = rst_n;
	end

endmodule

//--- test/decode_asserts.sv
`timescale 1ns/100ps

module decode_asserts import decode_pkg::*; (
	input logic          clock,
	input logic          rst_n,
	input logic          flush,
	input decoded_pack_t out_pack,
	input logic          out_illegal,
	input logic          halted
);

	// a rejected word never carries a packet
	illegal_no_packet: assert property (@(posedge clock) disable iff (!rst_n)
		!(out_illegal && out_pack.valid))
		else $error("out_illegal and out_pack.valid are high together");

	halted_sticky: assert property (@(posedge clock) disable iff (!rst_n)
		halted |=> halted)
		else $error("halted dropped while out of reset");

	flush_empties: assert property (@(posedge clock) disable iff (!rst_n)
		flush |=> !out_pack.valid)
		else $error("valid packet right after a flush");

endmodule

//--- test/decode_tb.sv
`timescale 1ns/100ps

module decode_tb import decode_pkg::*; ();

	localparam int PC_WIDTH = 32;
	localparam int REPEATS = 4;
	localparam int RANDOM_WORDS = 300;
	localparam int CSR_WORDS = 24;
	localparam int FLUSH_WORDS = 200;
	localparam int HALT_WORDS = 40;
	// generous upper bound on the stimulus length in cycles
	localparam int TOTAL_CYCLES = 5 + 16 + 64 * REPEATS + RANDOM_WORDS + 2 * CSR_WORDS +
		FLUSH_WORDS + 2 * HALT_WORDS + 32 + 6 * 3;

	localparam logic [31:0] M_OP = 32'h0000_007f;
	localparam logic [31:0] M_F3 = 32'h0000_707f;
	localparam logic [31:0] M_F7 = 32'hfe00_707f;

	logic                clock;
	logic                rst_n;
	logic                reset_req;
	logic                in_valid;
	inst_t               inst;
	logic [PC_WIDTH-1:0] in_pc;
	logic                flush;
	decoded_pack_t       decoded_pack;
	logic [PC_WIDTH-1:0] out_pc;
	logic                out_csr_op;
	logic                out_illegal;
	logic                halted;
	int                  errors;
	int                  checks;

	logic [31:0]         enc_mask[$];
	logic [31:0]         enc_bits[$];
	logic [PC_WIDTH-1:0] pc;
	int                  tests = 0;
	int                  errors_at_start = 0;

	tb_clock #(
		.RESET_CYCLES (5)
	) u_clock (
		.reset_req (reset_req),
		.clock     (clock),
		.rst_n     (rst_n)
	);

	decode_top #(
		.PC_WIDTH (PC_WIDTH)
	) i_dut (
		.clock        (clock),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.inst         (inst),
		.in_pc        (in_pc),
		.flush        (flush),
		.decoded_pack (decoded_pack),
		.out_pc       (out_pc),
		.out_csr_op   (out_csr_op),
		.out_illegal  (out_illegal),
		.halted       (halted)
	);

	decode_checker #(
		.PC_WIDTH (PC_WIDTH)
	) u_checker (
		.clock        (clock),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.inst         (inst),
		.in_pc        (in_pc),
		.flush        (flush),
		.decoded_pack (decoded_pack),
		.out_pc       (out_pc),
		.out_csr_op   (out_csr_op),
		.out_illegal  (out_illegal),
		.halted       (halted),
		.errors       (errors),
		.checks       (checks)
	);

	bind decode_stage decode_asserts u_asserts (
		.clock       (clock),
		.rst_n       (rst_n),
		.flush       (flush),
		.out_pack    (out_pack),
		.out_illegal (out_illegal),
		.halted      (halted)
	);

	function automatic logic [31:0] f3_op(input int f3, input logic [6:0] op);
		return {17'b0, 3'(f3), 5'b0, op};
	endfunction

	task automatic add_encoding(input logic [31:0] mask, input logic [31:0] bits);
		enc_mask.push_back(mask);
		enc_bits.push_back(bits);
	endtask

	// every supported RV32IM encoding except the system ones
	task automatic build_encodings();
		add_encoding(M_OP, {25'b0, OP_LUI});
		add_encoding(M_OP, {25'b0, OP_AUIPC});
		add_encoding(M_OP, {25'b0, OP_JAL});
		add_encoding(M_F3, f3_op(0, OP_JALR));
		for (int f = 0; f < 8; f++) begin
			if (f != 2 && f != 3)
				add_encoding(M_F3, f3_op(f, OP_BRANCH));
			if (f != 3 && f < 6)
				add_encoding(M_F3, f3_op(f, OP_LOAD));
			if (f < 3)
				add_encoding(M_F3, f3_op(f, OP_STORE));
			if (f != 1 && f != 5)
				add_encoding(M_F3, f3_op(f, OP_IMM));
			add_encoding(M_F7, f3_op(f, OP_REG));
			if (f < 4)
				add_encoding(M_F7, {FUNCT7_MULDIV, 25'b0} | f3_op(f, OP_REG));
		end
		add_encoding(M_F7, f3_op(1, OP_IMM));
		add_encoding(M_F7, f3_op(5, OP_IMM));
		add_encoding(M_F7, {FUNCT7_ALT, 25'b0} | f3_op(5, OP_IMM));
		add_encoding(M_F7, {FUNCT7_ALT, 25'b0} | f3_op(0, OP_REG));
		add_encoding(M_F7, {FUNCT7_ALT, 25'b0} | f3_op(5, OP_REG));
	endtask

	// random register fields and immediate around a fixed encoding
	function automatic logic [31:0] fill_encoding(input int idx);
		return ($urandom & ~enc_mask[idx]) | enc_bits[idx];
	endfunction

	function automatic logic [31:0] legal_word();
		return fill_encoding($urandom_range(0, enc_bits.size() - 1));
	endfunction

	function automatic logic [31:0] csr_word();
		return ($urandom & ~M_F3) | f3_op($urandom_range(1, 3), OP_SYSTEM);
	endfunction

	task automatic drive_word(input logic v, input logic [31:0] w, input logic f);
		@(posedge clock);
		in_valid <= v;
		inst <= w;
		in_pc <= pc;
		flush <= f;
		pc = pc + PC_WIDTH'(4);
	endtask

	task automatic idle_cycles(input int n);
		for (int k = 0; k < n; k++)
			drive_word(1'b0, $urandom, 1'b0);
	endtask

	// let the last input drain through the checker, then report
	task automatic end_test(input string name);
		idle_cycles(3);
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - errors_at_start);
		errors_at_start = errors;
	endtask

	initial begin
		#((TOTAL_CYCLES + 100) * 4);
		$display("timeout, stimulus still running after %0t", $time);
		$display("Something failed");
		$finish;
	end

	initial begin
		logic [31:0] w;

		in_valid = 1'b0;
		inst = '0;
		in_pc = '0;
		flush = 1'b0;
		reset_req = 1'b0;
		void'($urandom(32'hf5de_3e16));
		pc = PC_WIDTH'($urandom) & ~PC_WIDTH'(3);
		build_encodings();
		while (rst_n !== 1'b1)
			@(posedge clock);

		idle_cycles(16);
		end_test("idle after reset");

		for (int r = 0; r < REPEATS; r++) begin
			for (int idx = 0; idx < enc_bits.size(); idx++)
				drive_word(1'b1, fill_encoding(idx), 1'b0);
		end
		end_test("every encoding");

		// mostly unknown opcodes
		for (int n = 0; n < RANDOM_WORDS; n++) begin
			w = $urandom;
			if (w == WFI_INST)
				w = '0;
			drive_word($urandom_range(0, 7) != 0, w, 1'b0);
		end
		end_test("random words");

		for (int n = 0; n < CSR_WORDS; n++) begin
			drive_word(1'b1, csr_word(), 1'b0);
			drive_word(1'b1, legal_word(), 1'b0);
		end
		end_test("csr words");

		for (int n = 0; n < FLUSH_WORDS; n++)
			drive_word($urandom_range(0, 5) != 0, legal_word(), $urandom_range(0, 2) == 0);
		end_test("flush");

		for (int n = 0; n < 8; n++)
			drive_word(1'b1, legal_word(), 1'b0);
		// flushed wfi must not halt
		drive_word(1'b1, WFI_INST, 1'b1);
		for (int n = 0; n < 4; n++)
			drive_word(1'b1, legal_word(), 1'b0);
		drive_word(1'b1, WFI_INST, 1'b0);
		for (int n = 0; n < HALT_WORDS; n++)
			drive_word(1'b1, (n % 2 == 0) ? csr_word() : legal_word(), $urandom_range(0, 3) == 0);
		@(posedge clock);
		reset_req <= 1'b1;
		idle_cycles(3);
		reset_req <= 1'b0;
		idle_cycles(2);
		for (int n = 0; n < HALT_WORDS; n++)
			drive_word(1'b1, legal_word(), 1'b0);
		end_test("wfi halt and reset");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (checks == 0)
			$display("the checker compared no DUT output");
		if (errors == 0 && checks > 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- verilog.f
common/decode_pkg.sv
decode/imm_gen.sv
decode/decoder.sv
decode/decode_stage.sv
verilog/decode_top.sv
test/tb_clock.sv
test/decode_checker.sv
test/decode_asserts.sv
test/decode_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module decode_tb -f verilog.f \
	|| { echo "build failed"; exit 1; }
out=$(./obj_dir/Vdecode_tb)
echo "$out"
echo "$out" | grep -qx "Everything OK" && exit 0 || exit 1
